//--- src/decode_params.svh
////////////////////////////////////////
// Widths for the RV32I decode and issue stage
// Only the three base units are counted here
// Changing XLEN is not supported by the decode
////////////////////////////////////////
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Data path width
`define XLEN 32

// Register file address width
`define REG_ADDR_W 5

// ALU, branch and load/store
`define NUM_UNITS 3

// Branch and jump offset, JAL needs 21 bits
`define PC_OFFSET_W 21

// Load/store immediate offset
`define LS_OFFSET_W 12

`endif

//--- src/decode_pkg.sv
////////////////////////////////////////
// Types shared by the decode and issue stage
// Opcodes are the trimmed bits [6:2] of the
// instruction word, base ISA only
////////////////////////////////////////
package decode_pkg;

    // Major opcode, instruction bits [6:2]
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        FENCE     = 5'b00011,
        ARITH_IMM = 5'b00100,
        AUIPC     = 5'b00101,
        STORE     = 5'b01000,
        ARITH     = 5'b01100,
        LUI       = 5'b01101,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011,
        SYSTEM    = 5'b11100
    } opcode_t;

    // ALU result select
    typedef enum logic [1:0] {
        ALU_CONSTANT = 2'b00,
        ALU_ADD_SUB  = 2'b01,
        ALU_SLT      = 2'b10,
        ALU_SHIFT    = 2'b11
    } alu_op_t;

    // Logic op, LOGIC_ADD selects the adder
    typedef enum logic [1:0] {
        LOGIC_ADD = 2'b00,
        LOGIC_XOR = 2'b01,
        LOGIC_OR  = 2'b10,
        LOGIC_AND = 2'b11
    } alu_logic_op_t;

    // Bit positions in the unit vectors
    typedef enum logic [1:0] {
        ALU = 2'd0,
        BR  = 2'd1,
        LS  = 2'd2
    } unit_id_t;

endpackage

//--- src/issue_stage_if.sv
////////////////////////////////////////
// Issue stage signals shared by the
// controller, decoder and operand blocks
////////////////////////////////////////
`timescale 1ns/1ps
`include "decode_params.svh"

interface issue_stage_if import decode_pkg::*; ();

    // Issue stage enable
    logic              load;

    // Decode stage instruction
    logic [`XLEN-1:0]  decode_instr;
    logic [`XLEN-1:0]  decode_pc;

    // Issue stage copies
    logic [`XLEN-1:0]  issue_instr;
    logic [`XLEN-1:0]  issue_pc;
    logic [2:0]        issue_fn3;
    opcode_t           issue_opcode;

    modport ctrl (
        output load
    );

    modport decoder (
        input  load, decode_instr, decode_pc,
        output issue_instr, issue_pc, issue_fn3, issue_opcode
    );

    modport operand (
        input load, decode_instr, decode_pc,
        input issue_instr, issue_pc, issue_fn3, issue_opcode
    );

endinterface

//--- src/instr_decoder.sv
////////////////////////////////////////
// Field decode and unit selection
// Opcodes outside the base set select no
// unit and wait in issue for a flush
////////////////////////////////////////
`timescale 1ns/1ps
`include "decode_params.svh"

module instr_decoder import decode_pkg::*; (
    input  logic                   clk,
    issue_stage_if.decoder         iss,
    output logic [`NUM_UNITS-1:0]  unit_needed_o,
    output logic [1:0]             uses_rs_o,
    output logic [`REG_ADDR_W-1:0] issue_rs1_addr_o,
    output logic [`REG_ADDR_W-1:0] issue_rs2_addr_o
);

    opcode_t                opcode;
    logic [2:0]             fn3;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`NUM_UNITS-1:0]  unit_needed;
    logic [1:0]             uses_rs;

    ////////////////////////////////////////
    // Instruction fields
    assign opcode   = opcode_t'(iss.decode_instr[6:2]);
    assign fn3      = iss.decode_instr[14:12];
    assign rs1_addr = iss.decode_instr[19:15];
    assign rs2_addr = iss.decode_instr[24:20];

    ////////////////////////////////////////
    // Unit selection
    always_comb begin
        unit_needed      = '0;
        unit_needed[ALU] = opcode inside {ARITH, ARITH_IMM, AUIPC, LUI, JAL, JALR};
        unit_needed[BR]  = opcode inside {BRANCH, JAL, JALR};
        unit_needed[LS]  = opcode inside {LOAD, STORE, FENCE};
    end

    // Source usage for the in-use stall
    assign uses_rs[0] = opcode inside {JALR, BRANCH, LOAD, STORE, ARITH_IMM, ARITH};
    // Store data is read late, so rs2 is not checked
    assign uses_rs[1] = opcode inside {BRANCH, ARITH};

    ////////////////////////////////////////
    // Issue stage registers
    always_ff @(posedge clk) begin
        if (iss.load) begin
            iss.issue_instr  <= iss.decode_instr;
            iss.issue_pc     <= iss.decode_pc;
            iss.issue_fn3    <= fn3;
            iss.issue_opcode <= opcode;
            issue_rs1_addr_o <= rs1_addr;
            issue_rs2_addr_o <= rs2_addr;
            unit_needed_o    <= unit_needed;
            uses_rs_o        <= uses_rs;
        end
    end

endmodule

//--- src/issue_control.sv
////////////////////////////////////////
// Issue stage occupancy and issue strobes
// An instruction needing two units waits
// until both are ready
////////////////////////////////////////
`timescale 1ns/1ps
`include "decode_params.svh"

module issue_control (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  decode_valid_i,
    input  logic                  issue_hold_i,
    input  logic                  flush_i,
    input  logic [1:0]            rs_inuse_i,
    input  logic [`NUM_UNITS-1:0] unit_ready_i,
    input  logic [`NUM_UNITS-1:0] unit_needed_i,
    input  logic [1:0]            uses_rs_i,
    issue_stage_if.ctrl           iss,
    output logic                  decode_advance_o,
    output logic [`NUM_UNITS-1:0] issue_to_o,
    output logic                  instruction_issued_o
);

    logic stage_valid;
    logic operands_ready;
    logic units_ready;
    logic issue_valid;
    logic issued;
    logic stage_ready;

    ////////////////////////////////////////
    // Issue test
    assign operands_ready = ~|(rs_inuse_i & uses_rs_i);

    // Every needed unit ready, and at least one needed
    assign units_ready = (&(unit_ready_i | ~unit_needed_i)) & (|unit_needed_i);

    assign issue_valid = stage_valid & operands_ready & units_ready & ~issue_hold_i;
    assign issued      = issue_valid & ~flush_i;

    assign issue_to_o           = {`NUM_UNITS{issued}} & unit_needed_i;
    assign instruction_issued_o = issued;

    ////////////////////////////////////////
    // Stage advance
    // Stage takes a new instruction when empty or draining
    assign stage_ready      = (~stage_valid | issued) & ~issue_hold_i;
    assign iss.load         = stage_ready;
    assign decode_advance_o = decode_valid_i & stage_ready;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            stage_valid <= 1'b0;
        end else if (stage_ready) begin
            stage_valid <= decode_valid_i;
        end
    end

endmodule

//--- src/alu_operand_gen.sv
////////////////////////////////////////
// ALU operand bundle and constant adder
// Operands are 33 bits, the top bit is the
// sign or zero extension for compares
////////////////////////////////////////
`timescale 1ns/1ps
`include "decode_params.svh"

module alu_operand_gen import decode_pkg::*; (
    input  logic                       clk,
    input  logic [`XLEN-1:0]           rs1_data_i,
    input  logic [`XLEN-1:0]           rs2_data_i,
    issue_stage_if.operand             iss,
    output alu_op_t                    alu_op_o,
    output alu_logic_op_t              alu_logic_op_o,
    output logic                       alu_subtract_o,
    output logic [`XLEN:0]             alu_in1_o,
    output logic [`XLEN:0]             alu_in2_o,
    output logic [$clog2(`XLEN)-1:0]   alu_shift_amount_o,
    output logic                       alu_lshift_o,
    output logic                       alu_arith_o,
    output logic [`XLEN-1:0]           alu_constant_o
);

    opcode_t          opcode;
    logic [2:0]       fn3;
    alu_op_t          alu_op;
    alu_logic_op_t    logic_op;
    logic             sub_instr;
    logic             imm_type;
    logic [`XLEN-1:0] rs2_sel;

    assign opcode = opcode_t'(iss.decode_instr[6:2]);
    assign fn3    = iss.decode_instr[14:12];

    ////////////////////////////////////////
    // Decode side
    always_comb begin
        if (opcode inside {LUI, AUIPC, JAL, JALR}) begin
            alu_op = ALU_CONSTANT;
        end else if (fn3 inside {3'b010, 3'b011}) begin
            alu_op = ALU_SLT;
        end else if (fn3 inside {3'b001, 3'b101}) begin
            alu_op = ALU_SHIFT;
        end else begin
            alu_op = ALU_ADD_SUB;
        end
    end

    always_comb begin
        case (fn3)
            3'b100:  logic_op = LOGIC_XOR;
            3'b110:  logic_op = LOGIC_OR;
            3'b111:  logic_op = LOGIC_AND;
            default: logic_op = LOGIC_ADD;
        endcase
    end

    // SUB only exists in the register form
    assign sub_instr = (fn3 == 3'b000) && iss.decode_instr[30] && (opcode == ARITH);

    always_ff @(posedge clk) begin
        if (iss.load) begin
            alu_op_o       <= alu_op;
            alu_logic_op_o <= logic_op;
            alu_subtract_o <= (fn3 inside {3'b010, 3'b011}) || sub_instr;
            imm_type       <= (opcode == ARITH_IMM);
            // LUI: imm, AUIPC: pc + imm, jumps: pc + 4
            alu_constant_o <= ((opcode == LUI) ? '0 : iss.decode_pc)
                + ((opcode inside {LUI, AUIPC}) ? {iss.decode_instr[31:12], 12'b0}
                                                : `XLEN'd4);
        end
    end

    ////////////////////////////////////////
    // Issue side
    assign alu_lshift_o       = ~iss.issue_fn3[2];
    assign alu_shift_amount_o = imm_type ? iss.issue_instr[24:20] : rs2_data_i[4:0];
    // Shift-in bit for SRA and SRAI
    assign alu_arith_o        = rs1_data_i[`XLEN-1] & iss.issue_instr[30];

    assign rs2_sel = imm_type ? `XLEN'(signed'(iss.issue_instr[31:20])) : rs2_data_i;

    // fn3[0] marks SLTU, which zero-extends
    assign alu_in1_o = {rs1_data_i[`XLEN-1] & ~iss.issue_fn3[0], rs1_data_i};
    assign alu_in2_o = {rs2_sel[`XLEN-1] & ~iss.issue_fn3[0], rs2_sel};

endmodule

//--- src/branch_ls_operand_gen.sv
////////////////////////////////////////
// Branch and load/store operand bundles
// pc_p4_i comes from the ALU constant adder
////////////////////////////////////////
`timescale 1ns/1ps
`include "decode_params.svh"

module branch_ls_operand_gen import decode_pkg::*; (
    input  logic                    clk,
    input  logic [`XLEN-1:0]        rs1_data_i,
    input  logic [`XLEN-1:0]        rs2_data_i,
    input  logic [`XLEN-1:0]        pc_p4_i,
    issue_stage_if.operand          iss,
    output logic [2:0]              br_fn3_o,
    output logic [`PC_OFFSET_W-1:0] br_pc_offset_o,
    output logic                    br_jal_o,
    output logic                    br_jalr_o,
    output logic [`XLEN:0]          br_rs1_o,
    output logic [`XLEN:0]          br_rs2_o,
    output logic [`XLEN-1:0]        br_pc_p4_o,
    output logic                    ls_load_o,
    output logic                    ls_store_o,
    output logic                    ls_fence_o,
    output logic [`LS_OFFSET_W-1:0] ls_offset_o,
    output logic [2:0]              ls_fn3_o
);

    opcode_t                 opcode;
    logic [`XLEN-1:0]        instr;
    logic [`PC_OFFSET_W-1:0] pc_offset;
    logic                    use_signed;

    assign instr  = iss.decode_instr;
    assign opcode = opcode_t'(instr[6:2]);

    ////////////////////////////////////////
    // Offset select per jump type
    always_comb begin
        case (opcode)
            JAL:  pc_offset = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            JALR: pc_offset = `PC_OFFSET_W'(signed'(instr[31:20]));
            default: pc_offset = `PC_OFFSET_W'(signed'(
                {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
        endcase
    end

    always_ff @(posedge clk) begin
        if (iss.load) begin
            br_pc_offset_o <= pc_offset;
            // BLTU and BGEU compare unsigned
            use_signed     <= !(instr[14:12] inside {3'b110, 3'b111});
            br_jalr_o      <= (opcode == JALR);
            // Stores split the offset around rd
            ls_offset_o    <= (opcode == STORE) ? {instr[31:25], instr[11:7]}
                                                : instr[31:20];
            ls_load_o      <= (opcode == LOAD);
            ls_store_o     <= (opcode == STORE);
            ls_fence_o     <= (opcode == FENCE);
        end
    end

    ////////////////////////////////////////
    // Issue side
    assign br_fn3_o   = iss.issue_fn3;
    assign br_jal_o   = (iss.issue_opcode == JAL);
    assign br_pc_p4_o = pc_p4_i;
    assign br_rs1_o   = {rs1_data_i[`XLEN-1] & use_signed, rs1_data_i};
    assign br_rs2_o   = {rs2_data_i[`XLEN-1] & use_signed, rs2_data_i};
    assign ls_fn3_o   = iss.issue_fn3;

endmodule

//--- src/decode_issue_top.sv
////////////////////////////////////////
// Decode and issue top level
// One issue slot, units ALU, BR and LS
////////////////////////////////////////
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_issue_top import decode_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       decode_valid_i,
    input  logic [`XLEN-1:0]           decode_pc_i,
    input  logic [`XLEN-1:0]           decode_instr_i,
    output logic                       decode_advance_o,
    input  logic                       issue_hold_i,
    input  logic                       flush_i,
    input  logic [1:0]                 rs_inuse_i,
    input  logic [`XLEN-1:0]           rs1_data_i,
    input  logic [`XLEN-1:0]           rs2_data_i,
    input  logic [`NUM_UNITS-1:0]      unit_ready_i,
    output logic [`NUM_UNITS-1:0]      issue_to_o,
    output logic                       instruction_issued_o,
    output logic [`REG_ADDR_W-1:0]     issue_rs1_addr_o,
    output logic [`REG_ADDR_W-1:0]     issue_rs2_addr_o,
    // ALU
    output alu_op_t                    alu_op_o,
    output alu_logic_op_t              alu_logic_op_o,
    output logic                       alu_subtract_o,
    output logic [`XLEN:0]             alu_in1_o,
    output logic [`XLEN:0]             alu_in2_o,
    output logic [$clog2(`XLEN)-1:0]   alu_shift_amount_o,
    output logic                       alu_lshift_o,
    output logic                       alu_arith_o,
    output logic [`XLEN-1:0]           alu_constant_o,
    // Branch
    output logic [2:0]                 br_fn3_o,
    output logic [`PC_OFFSET_W-1:0]    br_pc_offset_o,
    output logic                       br_jal_o,
    output logic                       br_jalr_o,
    output logic [`XLEN:0]             br_rs1_o,
    output logic [`XLEN:0]             br_rs2_o,
    output logic [`XLEN-1:0]           br_pc_p4_o,
    // Load/store
    output logic                       ls_load_o,
    output logic                       ls_store_o,
    output logic                       ls_fence_o,
    output logic [`LS_OFFSET_W-1:0]    ls_offset_o,
    output logic [2:0]                 ls_fn3_o
);

    logic [`NUM_UNITS-1:0] unit_needed;
    logic [1:0]            uses_rs;

    issue_stage_if iss ();

    assign iss.decode_instr = decode_instr_i;
    assign iss.decode_pc    = decode_pc_i;

    instr_decoder u_decoder (
        .clk              (clk),
        .iss              (iss.decoder),
        .unit_needed_o    (unit_needed),
        .uses_rs_o        (uses_rs),
        .issue_rs1_addr_o (issue_rs1_addr_o),
        .issue_rs2_addr_o (issue_rs2_addr_o)
    );

    issue_control u_control (
        .clk                  (clk),
        .rst                  (rst),
        .decode_valid_i       (decode_valid_i),
        .issue_hold_i         (issue_hold_i),
        .flush_i              (flush_i),
        .rs_inuse_i           (rs_inuse_i),
        .unit_ready_i         (unit_ready_i),
        .unit_needed_i        (unit_needed),
        .uses_rs_i            (uses_rs),
        .iss                  (iss.ctrl),
        .decode_advance_o     (decode_advance_o),
        .issue_to_o           (issue_to_o),
        .instruction_issued_o (instruction_issued_o)
    );

    alu_operand_gen u_alu_gen (
        .clk                (clk),
        .rs1_data_i         (rs1_data_i),
        .rs2_data_i         (rs2_data_i),
        .iss                (iss.operand),
        .alu_op_o           (alu_op_o),
        .alu_logic_op_o     (alu_logic_op_o),
        .alu_subtract_o     (alu_subtract_o),
        .alu_in1_o          (alu_in1_o),
        .alu_in2_o          (alu_in2_o),
        .alu_shift_amount_o (alu_shift_amount_o),
        .alu_lshift_o       (alu_lshift_o),
        .alu_arith_o        (alu_arith_o),
        .alu_constant_o     (alu_constant_o)
    );

    branch_ls_operand_gen u_br_ls_gen (
        .clk            (clk),
        .rs1_data_i     (rs1_data_i),
        .rs2_data_i     (rs2_data_i),
        .pc_p4_i        (alu_constant_o),
        .iss            (iss.operand),
        .br_fn3_o       (br_fn3_o),
        .br_pc_offset_o (br_pc_offset_o),
        .br_jal_o       (br_jal_o),
        .br_jalr_o      (br_jalr_o),
        .br_rs1_o       (br_rs1_o),
        .br_rs2_o       (br_rs2_o),
        .br_pc_p4_o     (br_pc_p4_o),
        .ls_load_o      (ls_load_o),
        .ls_store_o     (ls_store_o),
        .ls_fence_o     (ls_fence_o),
        .ls_offset_o    (ls_offset_o),
        .ls_fn3_o       (ls_fn3_o)
    );

endmodule

//--- verif/tb_decode_issue.sv
////////////////////////////////////////
// Self-checking testbench for decode and issue
// Reads verif/decode_testdata.txt, so run it
// from the project root. Stops at the first
// mismatch. issue_hold_i stays low
////////////////////////////////////////
`timescale 1ns/1ps
`include "decode_params.svh"

module tb_decode_issue import decode_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int WORDS      = 10;
    localparam int MAX_VEC    = 32;
    localparam int MAX_STALLS = 4;

    logic                       clk;
    logic                       rst;
    logic                       decode_valid_i;
    logic [`XLEN-1:0]           decode_pc_i;
    logic [`XLEN-1:0]           decode_instr_i;
    logic                       decode_advance_o;
    logic                       issue_hold_i;
    logic                       flush_i;
    logic [1:0]                 rs_inuse_i;
    logic [`XLEN-1:0]           rs1_data_i;
    logic [`XLEN-1:0]           rs2_data_i;
    logic [`NUM_UNITS-1:0]      unit_ready_i;
    logic [`NUM_UNITS-1:0]      issue_to_o;
    logic                       instruction_issued_o;
    logic [`REG_ADDR_W-1:0]     issue_rs1_addr_o;
    logic [`REG_ADDR_W-1:0]     issue_rs2_addr_o;
    alu_op_t                    alu_op_o;
    alu_logic_op_t              alu_logic_op_o;
    logic                       alu_subtract_o;
    logic [`XLEN:0]             alu_in1_o;
    logic [`XLEN:0]             alu_in2_o;
    logic [$clog2(`XLEN)-1:0]   alu_shift_amount_o;
    logic                       alu_lshift_o;
    logic                       alu_arith_o;
    logic [`XLEN-1:0]           alu_constant_o;
    logic [2:0]                 br_fn3_o;
    logic [`PC_OFFSET_W-1:0]    br_pc_offset_o;
    logic                       br_jal_o;
    logic                       br_jalr_o;
    logic [`XLEN:0]             br_rs1_o;
    logic [`XLEN:0]             br_rs2_o;
    logic [`XLEN-1:0]           br_pc_p4_o;
    logic                       ls_load_o;
    logic                       ls_store_o;
    logic                       ls_fence_o;
    logic [`LS_OFFSET_W-1:0]    ls_offset_o;
    logic [2:0]                 ls_fn3_o;

    // Word 0 holds the vector count
    logic [31:0] vec_mem [0:MAX_VEC*WORDS];
    int          num_vec = 0;

    // Fields of the current vector
    logic [31:0] v_instr;
    logic [31:0] v_pc;
    logic [31:0] v_rs1;
    logic [31:0] v_rs2;
    logic [1:0]  v_inuse;
    logic [31:0] v_ctrl;
    logic [31:0] v_in2;
    logic [31:0] v_const;
    logic [31:0] v_pcoff;
    logic [31:0] v_lsoff;

    decode_issue_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task check_value(input string what, input logic [63:0] got, input logic [63:0] expected);
        if (got !== expected) begin
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, expected);
            $display("Finished with errors");
            $fatal(1, "Stopped at the first wrong value");
        end
    endtask

    task check_quiet(input string when, input logic advance_exp);
        check_value({"issue_to_o ", when}, 64'(issue_to_o), 64'd0);
        check_value({"instruction_issued_o ", when}, 64'(instruction_issued_o), 64'd0);
        check_value({"decode_advance_o ", when}, 64'(decode_advance_o), 64'(advance_exp));
    endtask

    ////////////////////////////////////////
    // Operand bundles in the issue cycle
    task check_bundles();
        if (v_ctrl[8]) begin
            check_value("alu_subtract_o", 64'(alu_subtract_o), 64'(v_ctrl[12]));
            check_value("alu_in1_o", 64'(alu_in1_o), 64'({v_ctrl[13], v_rs1}));
            check_value("alu_in2_o", 64'(alu_in2_o), 64'({v_ctrl[14], v_in2}));
        end
        if (v_ctrl[9]) begin
            check_value("alu_constant_o", 64'(alu_constant_o), 64'(v_const));
        end
        if (v_ctrl[10]) begin
            check_value("br_pc_offset_o", 64'(br_pc_offset_o), 64'(v_pcoff[20:0]));
            check_value("br_jal_o", 64'(br_jal_o), 64'(v_ctrl[18]));
            check_value("br_jalr_o", 64'(br_jalr_o), 64'(v_ctrl[19]));
            check_value("br_rs1_o", 64'(br_rs1_o), 64'({v_ctrl[16], v_rs1}));
            check_value("br_rs2_o", 64'(br_rs2_o), 64'({v_ctrl[17], v_rs2}));
        end
        if (v_ctrl[11]) begin
            check_value("ls_offset_o", 64'(ls_offset_o), 64'(v_lsoff[11:0]));
            check_value("ls_load_o", 64'(ls_load_o), 64'(v_ctrl[20]));
            check_value("ls_store_o", 64'(ls_store_o), 64'(v_ctrl[21]));
            check_value("ls_fence_o", 64'(ls_fence_o), 64'(v_ctrl[22]));
        end
    endtask

    ////////////////////////////////////////
    // Register fields, ALU controls and fn3 at issue
    task check_fields();
        opcode_t       op;
        logic [2:0]    fn3;
        alu_op_t       exp_op;
        alu_logic_op_t exp_logic;
        op  = opcode_t'(v_instr[6:2]);
        fn3 = v_instr[14:12];
        check_value("issue_rs1_addr_o", 64'(issue_rs1_addr_o), 64'(v_instr[19:15]));
        check_value("issue_rs2_addr_o", 64'(issue_rs2_addr_o), 64'(v_instr[24:20]));
        if (v_ctrl[8]) begin
            // SLT and SLTU compare, SLL, SRL and SRA shift
            case (fn3)
                3'b010, 3'b011: exp_op = ALU_SLT;
                3'b001, 3'b101: exp_op = ALU_SHIFT;
                default:        exp_op = ALU_ADD_SUB;
            endcase
            case (fn3)
                3'b100:  exp_logic = LOGIC_XOR;
                3'b110:  exp_logic = LOGIC_OR;
                3'b111:  exp_logic = LOGIC_AND;
                default: exp_logic = LOGIC_ADD;
            endcase
            check_value("alu_op_o", 64'(alu_op_o), 64'(exp_op));
            check_value("alu_logic_op_o", 64'(alu_logic_op_o), 64'(exp_logic));
            check_value("alu_shift_amount_o", 64'(alu_shift_amount_o),
                        64'((op == ARITH_IMM) ? v_instr[24:20] : v_rs2[4:0]));
            if (exp_op == ALU_SHIFT) begin
                check_value("alu_lshift_o", 64'(alu_lshift_o), 64'(fn3 == 3'b001));
                check_value("alu_arith_o", 64'(alu_arith_o),
                            64'(fn3 == 3'b101 && v_instr[30] && v_rs1[31]));
            end
        end else if (v_ctrl[0]) begin
            // LUI, AUIPC and the jumps use the constant adder
            check_value("alu_op_o", 64'(alu_op_o), 64'(ALU_CONSTANT));
        end
        if (v_ctrl[10]) begin
            check_value("br_fn3_o", 64'(br_fn3_o), 64'(fn3));
            check_value("br_pc_p4_o", 64'(br_pc_p4_o), 64'(v_pc + 32'd4));
        end
        if (v_ctrl[11]) begin
            check_value("ls_fn3_o", 64'(ls_fn3_o), 64'(fn3));
        end
    endtask

    // Offer the vector, the empty stage takes it at once
    task accept_vector();
        decode_valid_i = 1'b1;
        decode_instr_i = v_instr;
        decode_pc_i    = v_pc;
        rs1_data_i     = v_rs1;
        rs2_data_i     = v_rs2;
        rs_inuse_i     = 2'b00;
        unit_ready_i   = 3'b111;
        @(negedge clk);
        check_quiet("while empty", 1'b1);
        @(posedge clk);
        #2;
        decode_valid_i = 1'b0;
    endtask

    ////////////////////////////////////////
    // Issue with random stall cycles
    task issue_vector();
        int         stalls;
        int         kind;
        logic       done;
        logic [2:0] exp_to;
        stalls = 0;
        done   = 1'b0;
        exp_to = v_ctrl[2:0];
        while (!done) begin
            rs_inuse_i   = v_inuse;
            unit_ready_i = 3'b111;
            if (stalls < MAX_STALLS && ($urandom % 4) == 0) begin
                stalls = stalls + 1;
                kind   = int'($urandom % 3);
                // Same word offered again, a full stage must refuse it
                decode_valid_i = 1'b1;
                if (kind == 0) begin
                    unit_ready_i = 3'b000;
                end else if (kind == 1 && v_ctrl[5]) begin
                    rs_inuse_i = 2'b11;
                end else begin
                    // Drop only the lowest needed unit
                    unit_ready_i = 3'b111 ^ (exp_to & ~(exp_to - 3'd1));
                end
                @(negedge clk);
                check_quiet("during stall", 1'b0);
            end else begin
                decode_valid_i = 1'b0;
                @(negedge clk);
                check_value("issue_to_o", 64'(issue_to_o), 64'(exp_to));
                check_value("instruction_issued_o", 64'(instruction_issued_o), 64'd1);
                check_bundles();
                check_fields();
                done = 1'b1;
            end
            @(posedge clk);
            #2;
        end
        decode_valid_i = 1'b0;
        rs_inuse_i     = 2'b00;
        unit_ready_i   = 3'b111;
    endtask

    // Park the vector, then flush it away
    task flush_vector();
        decode_valid_i = 1'b1;
        rs_inuse_i     = 2'b11;
        unit_ready_i   = 3'b111;
        repeat (2) begin
            @(negedge clk);
            check_quiet("before flush", 1'b0);
            @(posedge clk);
            #2;
        end
        decode_valid_i = 1'b0;
        rs_inuse_i     = 2'b00;
        flush_i        = 1'b1;
        @(negedge clk);
        check_quiet("during flush", 1'b0);
        @(posedge clk);
        #2;
        flush_i = 1'b0;
        @(negedge clk);
        check_quiet("after flush", 1'b0);
        @(posedge clk);
        #2;
    endtask

    task run_vector(input int idx);
        int base;
        base    = 1 + idx * WORDS;
        v_instr = vec_mem[base];
        v_pc    = vec_mem[base + 1];
        v_rs1   = vec_mem[base + 2];
        v_rs2   = vec_mem[base + 3];
        v_inuse = vec_mem[base + 4][1:0];
        v_ctrl  = vec_mem[base + 5];
        v_in2   = vec_mem[base + 6];
        v_const = vec_mem[base + 7];
        v_pcoff = vec_mem[base + 8];
        v_lsoff = vec_mem[base + 9];
        accept_vector();
        if (v_ctrl[4]) begin
            flush_vector();
        end else begin
            issue_vector();
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    initial begin
        void'($urandom(97726));
        rst            = 1'b1;
        decode_valid_i = 1'b0;
        decode_pc_i    = '0;
        decode_instr_i = '0;
        issue_hold_i   = 1'b0;
        flush_i        = 1'b0;
        rs_inuse_i     = 2'b00;
        rs1_data_i     = '0;
        rs2_data_i     = '0;
        unit_ready_i   = 3'b111;
        $readmemh("verif/decode_testdata.txt", vec_mem);
        if (vec_mem[0] == 32'd0 || vec_mem[0] > 32'(MAX_VEC)) begin
            $display("Test data file is missing, empty or holds too many vectors");
            $display("Finished with errors");
            $fatal(1, "No usable test data");
        end
        num_vec = int'(vec_mem[0]);
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_quiet("after reset", 1'b0);
        @(posedge clk);
        #2;
        for (int i = 0; i < num_vec; i++) begin
            run_vector(i);
        end
        // The last vector must not issue twice
        @(negedge clk);
        check_value("issue_to_o at end", 64'(issue_to_o), 64'd0);
        $display("Finished with no errors");
        $finish;
    end

    // Watchdog, 60 cycles per vector
    initial begin
        wait (num_vec > 0);
        repeat (num_vec * 60 + 20) @(posedge clk);
        $display("Timeout: the DUT did not finish the vectors in the allowed cycles");
        $display("Finished with errors");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- verilog.f
+incdir+src
src/decode_pkg.sv
src/issue_stage_if.sv
src/instr_decoder.sv
src/issue_control.sv
src/alu_operand_gen.sv
src/branch_ls_operand_gen.sv
src/decode_issue_top.sv
verif/tb_decode_issue.sv

//--- Makefile
# Verilator build and run for the decode and issue stage
# Run make from the project root, the testbench reads verif/decode_testdata.txt

TOP := tb_decode_issue
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -o $(TOP)

# The simulator status is ignored here, the log decides pass or fail
run: compile
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verif/decode_testdata.txt
// First word is the vector count, then one vector per line, all hex
// instr pc rs1 rs2 inuse ctrl alu_in2 constant pc_offset ls_offset
// ctrl: [2:0] issue_to, [4] flush, [5] uses a source, [8] alu ops, [9] constant,
// [10] branch, [11] ld/st, [12] sub, [13] in1 ext, [14] in2 ext, [16] br rs1 ext,
// [17] br rs2 ext, [18] jal, [19] jalr, [20] load, [21] store, [22] fence
00000013
// add x3, x1, x2
002081B3 00000100 00000010 00000020 0 000321 00000020 00000104 000000 000
// sub x5, x6, x7
407302B3 00000104 80000000 FFFFFFFF 0 007321 FFFFFFFF 00000108 000000 000
// sltu x4, x1, x2
0020B233 00000108 FFFFFFF0 80000000 0 001321 80000000 0000010C 000000 000
// slt x4, x1, x2
0020A233 0000010C FFFFFFF0 00000005 0 003321 00000005 00000110 000000 000
// addi x1, x2, -3 with rs2 busy
FFD10093 00000110 00001000 12345678 2 004321 FFFFFFFD 00000114 000000 000
// sltiu x6, x7, -2048
8003B313 00000114 7FFFFFFF 00000000 2 001321 FFFFF800 00000118 000000 000
// lui x10, 0x12345
12345537 00000200 00000000 00000000 3 000201 00000000 12345000 000000 000
// auipc x11, 0x10
00010597 00000300 00000000 00000000 0 000201 00000000 00010300 000000 000
// jal x1, +8
008000EF 00000400 00000011 00000022 3 040603 00000000 00000404 000008 000
// jal x0, -16
FF1FF06F 00000500 00000001 00000002 0 040603 00000000 00000504 1FFFF0 000
// jalr x1, 12(x5)
00C280E7 00000600 00001000 00000000 2 080623 00000000 00000604 00000C 000
// beq x1, x2, +16
00208863 00000700 80000000 00000001 0 010422 00000000 00000000 000010 000
// bltu x3, x4, -8
FE41ECE3 00000704 FFFFFFFF 80000000 0 000422 00000000 00000000 1FFFF8 000
// lw x5, 36(x2)
02412283 00000800 00002000 00000000 2 100824 00000000 00000000 000000 024
// sw x6, -4(x7) with rs2 busy
FE63AE23 00000804 00002000 DEADBEEF 2 200824 00000000 00000000 000000 FFC
// fence
0FF0000F 00000808 00000000 00000000 3 400804 00000000 00000000 000000 0FF
// add x3, x1, x2, flushed
002081B3 00000900 00000010 00000020 0 000030 00000000 00000000 000000 000
// ecall needs no unit, flushed
00000073 00000904 00000000 00000000 0 000010 00000000 00000000 000000 000
// or x1, x2, x3
003160B3 00000908 0F0F0F0F F0F0F0F0 0 004321 F0F0F0F0 0000090C 000000 000
